// ==== fetch.f ====
+incdir+include
hw/fetch_pkg.sv
hw/fetch_pkt_if.sv
hw/if_stage.sv
hw/imem_rom.sv
hw/if_id_reg.sv
hw/jal_redirect.sv
hw/fetch_top.sv
sim/fetch_sva.sv
sim/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/fetch_pkg.sv
      - hw/fetch_pkt_if.sv
      - hw/if_stage.sv
      - hw/imem_rom.sv
      - hw/if_id_reg.sv
      - hw/jal_redirect.sv
      - hw/fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/fetch_sva.sv
      - sim/fetch_tb.sv

// ==== sim/fetch_tb.sv ====
/*
 * fetch front end testbench
 * loads programs into the instruction memory, drives
 * redirects and stalls, and compares the decode packet
 * against a cycle-level PC model
 */

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int WORDS    = 2 * `IMEM_LINES;
	localparam int LOAD_LEN = `IMEM_LINES + 5;            // load plus reset tail
	localparam int RUN_LEN  = 40 + 40 + 30 + 60 + 40 + 100;   // tests plus pc waits
	localparam longint WATCH_NS = longint'(5 * LOAD_LEN + RUN_LEN + 200) * 20;

	logic      clock;
	logic      reset;
	logic      load_en;
	line_idx_t load_idx;
	mem_line_t load_data;
	logic      ex_take_branch;
	addr_t     ex_target_pc;
	logic      id_stall;
	logic      id_valid;
	addr_t     id_pc;
	addr_t     id_npc;
	inst_t     id_inst;

	inst_t       prog [WORDS];      // program image, one entry per word
	addr_t       jal_off [WORDS];   // offset each placed JAL was encoded with
	logic [31:0] rng_state = 32'h42b6;
	int          fail_count = 0;
	int          tests_run = 0;

	// model state, predicted decode packet
	addr_t model_pc;
	logic  exp_valid;
	addr_t exp_pc;
	inst_t exp_inst;
	logic  m_jal;
	addr_t m_jal_target;
	int    jal_hits = 0;
	int    ex_hits = 0;
	int    stall_cycles = 0;
	int    prio_hits = 0;        // ex strobe while a JAL sits in decode
	int    stall_redir_hits = 0; // ex strobe during a stall
	int    lo_words = 0;         // valid slots holding a low-half word
	int    hi_words = 0;         // valid slots holding a high-half word

	fetch_top dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int word_of(input addr_t a);
		return int'(a[`IMEM_IDX_BITS+2:2]);   // word slot, wraps like the memory
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#2;   // inputs settle well before the next edge
	endtask

	// ALU filler everywhere, opcode never JAL
	task automatic fill_program();
		for (int i = 0; i < WORDS; i++) begin
			rng_state = xorshift32(rng_state);
			prog[i] = {rng_state[31:7], rng_state[0] ? 7'b0110011 : 7'b0010011};
			jal_off[i] = '0;
		end
	endtask

	// jal x1, offset in ISA bit order
	task automatic place_jal(input int idx, input int offset);
		logic [20:0] imm;
		imm = 21'(offset);
		prog[idx] = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
		jal_off[idx] = addr_t'(offset);
	endtask

	// whole memory written under reset, then three more reset cycles
	task automatic load_program();
		reset = 1'b1;
		for (int i = 0; i < `IMEM_LINES; i++) begin
			next_cycle();
			load_en   = 1'b1;
			load_idx  = line_idx_t'(i);
			load_data = {prog[2*i+1], prog[2*i]};   // low address in low half
		end
		next_cycle();
		load_en = 1'b0;
		repeat (3) next_cycle();
		reset = 1'b0;
	endtask

	task automatic strobe_branch(input addr_t target);
		ex_take_branch = 1'b1;
		ex_target_pc   = target;
		next_cycle();
		ex_take_branch = 1'b0;
	endtask

	task automatic wait_for_pc(input addr_t pc);
		int n;
		n = 0;
		while (!(id_valid && id_pc == pc) && n < 50) begin
			next_cycle();
			n++;
		end
		if (!(id_valid && id_pc == pc)) begin
			$display("pc %h never showed up in decode", pc);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name, input bit reached, input int start);
		if (!reached) begin
			$display("%s: stimulus never produced the case it targets", name);
			fail_count++;
		end
		tests_run++;
		$display("test %0d %s: done, %0d failures", tests_run, name, fail_count - start);
	endtask

	////////////////////////////////////////
	// PC model
	////////////////////////////////////////

	assign m_jal = exp_valid && (exp_inst[6:0] == OPC_JAL) && !id_stall && !ex_take_branch;
	assign m_jal_target = exp_pc + jal_off[word_of(exp_pc)];

	always @(posedge clock) begin
		if (reset) begin
			model_pc  <= '0;
			exp_valid <= 1'b0;
			exp_inst  <= `NOP_INST;
		end else begin
			if (ex_take_branch)      model_pc <= ex_target_pc;   // execute first
			else if (m_jal)          model_pc <= m_jal_target;
			else if (!id_stall)      model_pc <= model_pc + 4;
			if (ex_take_branch || m_jal) begin
				exp_valid <= 1'b0;            // wrong-path slot removed
				exp_inst  <= `NOP_INST;
			end else if (!id_stall) begin
				exp_valid <= 1'b1;
				exp_pc    <= model_pc;
				exp_inst  <= prog[word_of(model_pc)];
			end
			// event counts, to see that each case was reached
			if (m_jal) jal_hits++;
			if (ex_take_branch) ex_hits++;
			if (id_stall) stall_cycles++;
			if (ex_take_branch && exp_valid && exp_inst[6:0] == OPC_JAL) prio_hits++;
			if (ex_take_branch && id_stall) stall_redir_hits++;
			if (exp_valid && exp_pc[2]) hi_words++;
			if (exp_valid && !exp_pc[2]) lo_words++;
		end
	end

	////////////////////////////////////////
	// checks against the model
	////////////////////////////////////////

	a_valid: assert property (@(posedge clock) disable iff (reset) id_valid == exp_valid)
		else begin
			fail_count++;
			$display("[FAIL] %0t id_valid %b, expected %b", $time,
				$sampled(id_valid), $sampled(exp_valid));
		end

	a_pc: assert property (@(posedge clock) disable iff (reset) exp_valid |-> id_pc == exp_pc)
		else begin
			fail_count++;
			$display("[FAIL] %0t id_pc %h, expected %h", $time,
				$sampled(id_pc), $sampled(exp_pc));
		end

	a_inst: assert property (@(posedge clock) disable iff (reset)
		exp_valid |-> id_inst == exp_inst)
		else begin
			fail_count++;
			$display("[FAIL] %0t id_inst %h at pc %h, expected %h", $time,
				$sampled(id_inst), $sampled(exp_pc), $sampled(exp_inst));
		end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		int start;
		int j0;
		int e0;
		int s0;
		int p0;
		int r0;
		int lo0;
		int hi0;
		reset          = 1'b1;
		load_en        = 1'b0;
		load_idx       = '0;
		load_data      = '0;
		ex_take_branch = 1'b0;
		ex_target_pc   = '0;
		id_stall       = 1'b0;

		// sequential fetch, both halves of each line
		start = fail_count;
		fill_program();
		load_program();
		lo0 = lo_words;
		hi0 = hi_words;
		repeat (40) next_cycle();
		report_test("sequential fetch", lo_words - lo0 >= 8 && hi_words - hi0 >= 8, start);

		// forward jumps from odd and even words, then a backward loop
		start = fail_count;
		fill_program();
		place_jal(5, 40);
		place_jal(20, 60);
		place_jal(40, -16);
		load_program();
		j0 = jal_hits;
		repeat (40) next_cycle();
		report_test("early jal redirect", jal_hits - j0 >= 3, start);

		// late redirects from execute
		start = fail_count;
		fill_program();
		load_program();
		e0 = ex_hits;
		repeat (6) next_cycle();
		strobe_branch(32'h100);
		repeat (8) next_cycle();
		strobe_branch(32'h24);
		repeat (10) next_cycle();
		report_test("late execute redirect", ex_hits - e0 >= 2, start);

		// stalls, one of them with a JAL held in decode
		start = fail_count;
		fill_program();
		place_jal(14, 24);
		load_program();
		s0 = stall_cycles;
		j0 = jal_hits;
		repeat (5) next_cycle();
		id_stall = 1'b1;
		repeat (4) next_cycle();
		id_stall = 1'b0;
		repeat (6) next_cycle();
		wait_for_pc(32'd56);
		id_stall = 1'b1;
		repeat (3) next_cycle();
		id_stall = 1'b0;
		repeat (10) next_cycle();
		report_test("stall", stall_cycles - s0 >= 7 && jal_hits - j0 >= 1, start);

		// execute beats a JAL in decode, and a redirect lands during a stall
		start = fail_count;
		fill_program();
		place_jal(6, 40);
		load_program();
		p0 = prio_hits;
		r0 = stall_redir_hits;
		wait_for_pc(32'd24);
		strobe_branch(32'h80);
		repeat (6) next_cycle();
		id_stall = 1'b1;
		repeat (2) next_cycle();
		strobe_branch(32'h40);   // still stalled here
		next_cycle();
		id_stall = 1'b0;
		repeat (8) next_cycle();
		report_test("priority", prio_hits - p0 >= 1 && stall_redir_hits - r0 >= 1, start);

		// failures seen by the bound protocol checker
		fail_count = fail_count + dut_i.fetch_sva_i.err_count;

		$display("tests run %0d, failures %0d", tests_run, fail_count);
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCH_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCH_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sim/fetch_sva.sv ====
/*
 * fetch front end assertions
 * protocol checks on the decode packet ports,
 * bound into the top level
 */

`timescale 1ns/1ps

module fetch_sva (
	input logic             clock,
	input logic             reset,
	input logic             ex_take_branch,
	input logic             id_stall,
	input logic             id_valid,
	input fetch_pkg::addr_t id_pc,
	input fetch_pkg::addr_t id_npc,
	input fetch_pkg::inst_t id_inst
);
	import fetch_pkg::*;

	int err_count = 0;   // assertion failures so far

	////////////////////////////////////////
	// packet fields
	////////////////////////////////////////

	// npc is always the sequential successor
	npc_seq: assert property (@(posedge clock) disable iff (reset)
		id_valid |-> id_npc == addr_t'(id_pc + 4))
		else begin
			err_count++;
			$error("id_npc is not id_pc plus 4");
		end

	////////////////////////////////////////
	// redirect and stall
	////////////////////////////////////////

	// slot behind a late redirect is dropped
	ex_bubble: assert property (@(posedge clock) disable iff (reset)
		ex_take_branch |=> !id_valid)
		else begin
			err_count++;
			$error("valid packet right after an execute redirect");
		end

	// no jal redirect can fire under a stall, so only execute can disturb it
	stall_hold: assert property (@(posedge clock) disable iff (reset)
		id_stall && !ex_take_branch |=> $stable(id_valid) && $stable(id_pc)
			&& $stable(id_inst))
		else begin
			err_count++;
			$error("decode packet changed during a stall");
		end

	// covers every reset cycle and the first one after it
	reset_empty: assert property (@(posedge clock) reset |=> !id_valid)
		else begin
			err_count++;
			$error("valid packet during or just after reset");
		end

endmodule

bind fetch_top fetch_sva fetch_sva_i (
	.clock          (clock),
	.reset          (reset),
	.ex_take_branch (ex_take_branch),
	.id_stall       (id_stall),
	.id_valid       (id_valid),
	.id_pc          (id_pc),
	.id_npc         (id_npc),
	.id_inst        (id_inst)
);

// ==== hw/fetch_top.sv ====
/*
 * fetch front end top level
 * fetch stage, instruction memory, IF/ID register and
 * the early JAL redirect, joined into one block with
 * plain ports for the loader, execute and decode
 */

`timescale 1ns/1ps

module fetch_top (
	input  logic                 clock,
	input  logic                 reset,
	// memory loading
	input  logic                 load_en,
	input  fetch_pkg::line_idx_t load_idx,
	input  fetch_pkg::mem_line_t load_data,
	// late redirect from execute
	input  logic                 ex_take_branch,
	input  fetch_pkg::addr_t     ex_target_pc,
	// decode back-pressure
	input  logic                 id_stall,
	// decode packet
	output logic                 id_valid,
	output fetch_pkg::addr_t     id_pc,
	output fetch_pkg::addr_t     id_npc,
	output fetch_pkg::inst_t     id_inst
);
	import fetch_pkg::*;

	line_idx_t imem_idx;     // fetch -> memory
	mem_line_t imem_line;    // memory -> fetch
	logic      jal_take;     // early redirect strobe
	addr_t     jal_target;
	logic      flush;        // kill IF/ID slot

	fetch_pkt_if if_pkt ();   // fetch -> IF/ID
	fetch_pkt_if id_pkt ();   // IF/ID -> decode

	////////////////////////////////////////
	// fetch and memory
	////////////////////////////////////////

	if_stage if_stage_i (
		.clock          (clock),
		.reset          (reset),
		.ex_take_branch (ex_take_branch),
		.ex_target_pc   (ex_target_pc),
		.jal_take       (jal_take),
		.jal_target     (jal_target),
		.id_stall       (id_stall),
		.imem_line      (imem_line),
		.imem_idx       (imem_idx),
		.pkt            (if_pkt.src)
	);

	imem_rom imem_i (
		.clock   (clock),
		.rd_idx  (imem_idx),
		.wr_en   (load_en),
		.wr_idx  (load_idx),
		.wr_data (load_data),
		.rd_line (imem_line)
	);

	////////////////////////////////////////
	// IF/ID and decode-side redirect
	////////////////////////////////////////

	if_id_reg if_id_i (
		.clock (clock),
		.reset (reset),
		.stall (id_stall),
		.flush (flush),
		.in    (if_pkt.dst),
		.out   (id_pkt.src)
	);

	jal_redirect jal_i (
		.id             (id_pkt.dst),
		.id_stall       (id_stall),
		.ex_take_branch (ex_take_branch),
		.jal_take       (jal_take),
		.jal_target     (jal_target),
		.flush          (flush)
	);

	// decode packet out to the ports
	assign id_valid = id_pkt.valid;
	assign id_pc    = id_pkt.pc;
	assign id_npc   = id_pkt.npc;
	assign id_inst  = id_pkt.inst;

endmodule

// ==== hw/jal_redirect.sv ====
/*
 * early JAL redirect
 * looks at the decode packet, spots JAL, forms its
 * target and steers fetch there a cycle before execute
 * would; yields to a late redirect from execute
 */

`timescale 1ns/1ps

`include "fetch_settings.svh"

module jal_redirect (
	fetch_pkt_if.dst         id,               // packet in decode
	input  logic             id_stall,         // decode held, do not act yet
	input  logic             ex_take_branch,   // older redirect from execute
	output logic             jal_take,         // strobe toward fetch
	output fetch_pkg::addr_t jal_target,       // jump destination
	output logic             flush             // kill the IF/ID slot
);
	import fetch_pkg::*;

	logic  is_jal;     // valid packet with JAL opcode
	addr_t j_imm;      // sign-extended J immediate

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	assign is_jal = id.valid && (id.inst[6:0] == OPC_JAL);

	// J-type immediate is scattered over inst[31:12]
	//   inst[31]    -> imm[20]
	//   inst[30:21] -> imm[10:1]
	//   inst[20]    -> imm[11]
	//   inst[19:12] -> imm[19:12]
	assign j_imm = {
		{(`XLEN-20){id.inst[31]}},   // sign
		id.inst[19:12],
		id.inst[20],
		id.inst[30:21],
		1'b0                         // targets are halfword aligned
	};

	assign jal_target = id.pc + j_imm;

	////////////////////////////////////////
	// redirect and flush
	////////////////////////////////////////

	// execute holds an older instruction, its redirect wins
	assign jal_take = is_jal && !id_stall && !ex_take_branch;

	// either redirect leaves a wrong-path word behind in fetch
	assign flush = jal_take || ex_take_branch;

endmodule

// ==== hw/if_id_reg.sv ====
/*
 * IF/ID pipeline register
 * captures the fetch packet each cycle, holds it while
 * decode stalls, and turns it into a bubble on flush
 */

`timescale 1ns/1ps

`include "fetch_settings.svh"

module if_id_reg (
	input  logic      clock,
	input  logic      reset,
	input  logic      stall,   // decode cannot accept, hold contents
	input  logic      flush,   // wrong-path slot, drop it
	fetch_pkt_if.dst  in,      // packet from fetch
	fetch_pkt_if.src  out      // packet seen by decode
);
	import fetch_pkg::*;

	logic  valid_q;
	addr_t pc_q;
	addr_t npc_q;
	inst_t inst_q;

	////////////////////////////////////////
	// register update
	////////////////////////////////////////

	// flush beats stall, a redirect during a stall still kills the slot
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= 1'b0;
			inst_q  <= `NOP_INST;   // bubble
		end else if (!stall) begin
			valid_q <= in.valid;
			inst_q  <= in.inst;
		end
	end

	// pc fields carry no control meaning, only stall gates them
	always_ff @(posedge clock) begin
		if (!stall || flush) begin
			pc_q  <= in.pc;
			npc_q <= in.npc;
		end
	end

	assign out.valid = valid_q;
	assign out.pc    = pc_q;
	assign out.npc   = npc_q;
	assign out.inst  = inst_q;

endmodule

// ==== hw/imem_rom.sv ====
/*
 * instruction memory
 * array of 64-bit lines, read combinationally by fetch,
 * written one line per clock by the loader
 * contents are kept across reset
 */

`timescale 1ns/1ps

`include "fetch_settings.svh"

module imem_rom (
	input  logic                 clock,
	input  fetch_pkg::line_idx_t rd_idx,    // fetch line index
	input  logic                 wr_en,     // load strobe
	input  fetch_pkg::line_idx_t wr_idx,    // line to load
	input  fetch_pkg::mem_line_t wr_data,   // two instruction words
	output fetch_pkg::mem_line_t rd_line    // line at rd_idx, same cycle
);
	import fetch_pkg::*;

	mem_line_t mem [`IMEM_LINES];   // the storage itself

	////////////////////////////////////////
	// read port
	////////////////////////////////////////

	// asynchronous so the fetch packet forms in the same cycle as the pc
	assign rd_line = mem[rd_idx];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_data;   // one line per strobe
		end
	end

endmodule

// ==== hw/if_stage.sv ====
/*
 * instruction fetch stage
 * holds the PC, picks the next PC from the redirect
 * sources and the stall, addresses the 64-bit memory
 * and selects the 32-bit word for the fetch packet
 */

`timescale 1ns/1ps

`include "fetch_settings.svh"

module if_stage (
	input  logic                clock,
	input  logic                reset,
	input  logic                ex_take_branch,   // late redirect from execute
	input  fetch_pkg::addr_t    ex_target_pc,
	input  logic                jal_take,         // early redirect from decode
	input  fetch_pkg::addr_t    jal_target,
	input  logic                id_stall,         // decode back-pressure, a level
	input  fetch_pkg::mem_line_t imem_line,       // line read back from memory
	output fetch_pkg::line_idx_t imem_idx,        // line being fetched
	fetch_pkt_if.src            pkt               // packet toward IF/ID
);
	import fetch_pkg::*;

	addr_t pc_reg;      // pc currently in fetch
	addr_t pc_plus_4;   // sequential successor
	addr_t next_pc;     // value loaded on the next edge

	assign pc_plus_4 = pc_reg + `XLEN'd4;

	////////////////////////////////////////
	// next pc selection
	////////////////////////////////////////

	// redirects win over the stall so neither is dropped
	always_comb begin
		if (ex_take_branch) begin
			next_pc = ex_target_pc;   // resolved branch in execute
		end else if (jal_take) begin
			next_pc = jal_target;     // jal caught in decode
		end else if (id_stall) begin
			next_pc = pc_reg;         // hold
		end else begin
			next_pc = pc_plus_4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;   // boot from address 0
		end else begin
			pc_reg <= next_pc;
		end
	end

	////////////////////////////////////////
	// memory address and word select
	////////////////////////////////////////

	// bits [2:0] pick a byte inside the line, drop them
	assign imem_idx = pc_reg[`IMEM_IDX_BITS+2:3];

	// pc bit 2 chooses the high word of the line
	assign pkt.inst  = pc_reg[2] ? imem_line[63:32] : imem_line[31:0];
	assign pkt.pc    = pc_reg;
	assign pkt.npc   = pc_plus_4;
	assign pkt.valid = !reset;    // fetch always has a word once out of reset

endmodule

// ==== hw/fetch_pkt_if.sv ====
/*
 * fetch packet interface
 * carries one fetched instruction with its pc and
 * sequential next pc between pipeline blocks
 */

`timescale 1ns/1ps

interface fetch_pkt_if;
	import fetch_pkg::*;

	logic  valid;   // slot holds a real instruction
	addr_t pc;      // address of inst
	addr_t npc;     // pc + 4
	inst_t inst;    // instruction word

	// producer side
	modport src (
		output valid, pc, npc, inst
	);

	// consumer side
	modport dst (
		input valid, pc, npc, inst
	);

endinterface

// ==== hw/fetch_pkg.sv ====
/*
 * fetch package
 * shared types for the fetch front end and the
 * opcode constant used by the early JAL redirect
 */

`include "fetch_settings.svh"

package fetch_pkg;

	////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////

	// program counter or byte address
	typedef logic [`XLEN-1:0] addr_t;

	// one 32-bit instruction word
	typedef logic [31:0] inst_t;

	// one memory line, lower address word in the low half
	typedef logic [63:0] mem_line_t;

	// index of a memory line
	typedef logic [`IMEM_IDX_BITS-1:0] line_idx_t;

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	localparam logic [6:0] OPC_JAL = 7'b1101111;   // jump and link

endpackage

// ==== include/fetch_settings.svh ====
/*
 * fetch front end settings
 * word width, instruction memory geometry and the
 * encoding used for an empty pipeline slot
 */

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address and data word width
`define XLEN 32

// instruction memory, 64-bit lines holding two words each
`define IMEM_LINES    256
`define IMEM_IDX_BITS 8       // log2 of IMEM_LINES

// addi x0,x0,0, placed in a bubble
`define NOP_INST 32'h0000_0013

`endif
